// File: Makefile
TOP := apb_regs_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir

// File: filelist.f
hdl/apb_regs_pkg.sv
hdl/apb_reg_bank.sv
hdl/apb_addr_decoder.sv
hdl/apb_regs_top.sv
tb/tb_clock_gen.sv
tb/apb_regs_asserts.sv
tb/apb_regs_tb.sv

// File: hdl/apb_addr_decoder.sv
`timescale 1ns/10ps

module apb_addr_decoder (
	input  logic pclk,
	input  logic preset_n,
	input  apb_regs_pkg::apb_req_t req,
	input  apb_regs_pkg::apb_rsp_t [apb_regs_pkg::NUM_BANKS-1:0] bank_rsp,
	output logic [apb_regs_pkg::NUM_BANKS-1:0] bank_psel,
	output apb_regs_pkg::reg_sel_t reg_sel,
	output apb_regs_pkg::apb_rsp_t rsp
);

	// address fields
	logic [apb_regs_pkg::BANK_W-1:0] bank_idx;
	logic [apb_regs_pkg::REG_IDX_W-1:0] reg_idx;

	// bank index beyond the last mapped bank
	logic unmapped;

	// error responder state
	logic err_access;
	logic err_ready;
	logic err_done;

	// merged response before it leaves the decoder
	apb_regs_pkg::apb_rsp_t merged;

	// upper bits pick the bank, lower bits the register
	assign bank_idx = req.paddr[apb_regs_pkg::ADDR_W-1:apb_regs_pkg::BANK_LSB];
	assign reg_idx = req.paddr[apb_regs_pkg::BANK_LSB-1:0];

	assign unmapped = (bank_idx >= apb_regs_pkg::BANK_W'(apb_regs_pkg::NUM_BANKS));

	// per bank psel
	// at most one bit is set, none for an unmapped index
	always_comb begin
		for (int b = 0; b < apb_regs_pkg::NUM_BANKS; b++) begin
			bank_psel[b] = req.psel && (bank_idx == apb_regs_pkg::BANK_W'(b));
		end
	end

	// register field to one-hot
	// shared by all banks, each bank qualifies it with its own psel
	always_comb begin
		for (int i = 0; i < apb_regs_pkg::REGS_PER_BANK; i++) begin
			reg_sel[i] = (reg_idx == apb_regs_pkg::REG_IDX_W'(i));
		end
	end

	// error responder for unmapped addresses
	// same one wait cycle as a bank so the master sees one timing
	assign err_access = req.psel && req.penable && unmapped && !err_done;

	always_ff @(posedge pclk or negedge preset_n) begin
		if (!preset_n) begin
			err_ready <= 1'b0;
			err_done <= 1'b0;
		end else begin
			err_ready <= err_access;
			if (err_access) begin
				err_done <= 1'b1;
			end else if (!(req.psel && req.penable)) begin
				err_done <= 1'b0;
			end
		end
	end

	// response merge
	// only the addressed completer pulses pready, so an or is enough
	// read data of a bank passes only in its ready cycle
	// an idle bank still holds its last read byte
	always_comb begin
		merged.pready = err_ready;
		merged.pslverr = err_ready;
		// error cycle drives zero data
		merged.prdata = '0;
		for (int b = 0; b < apb_regs_pkg::NUM_BANKS; b++) begin
			merged.pready = merged.pready | bank_rsp[b].pready;
			merged.pslverr = merged.pslverr | bank_rsp[b].pslverr;
			if (bank_rsp[b].pready) begin
				merged.prdata = merged.prdata | bank_rsp[b].prdata;
			end
		end
	end

	assign rsp = merged;

endmodule

// File: hdl/apb_reg_bank.sv
`timescale 1ns/10ps

module apb_reg_bank (
	input  logic pclk,
	input  logic preset_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  apb_regs_pkg::reg_sel_t reg_sel,
	input  logic [apb_regs_pkg::DATA_W-1:0] pwdata,
	output apb_regs_pkg::apb_rsp_t rsp
);

	// register storage
	logic [apb_regs_pkg::DATA_W-1:0] mem [apb_regs_pkg::REGS_PER_BANK];

	// byte picked out by the one-hot select
	logic [apb_regs_pkg::DATA_W-1:0] sel_data;

	// registered read data, holds until the next read
	logic [apb_regs_pkg::DATA_W-1:0] rd_data;

	// handshake state
	logic ready;
	logic done;
	logic access;

	// first access cycle of a transfer
	// done masks the second access cycle while pready is high
	assign access = psel && penable && !done;

	// read mux built as an and-or tree over the one-hot select
	// an all-zero select reads back zero
	always_comb begin
		sel_data = '0;
		for (int i = 0; i < apb_regs_pkg::REGS_PER_BANK; i++) begin
			if (reg_sel[i]) begin
				sel_data = sel_data | mem[i];
			end
		end
	end

	// ready pulse and done flag
	always_ff @(posedge pclk or negedge preset_n) begin
		if (!preset_n) begin
			ready <= 1'b0;
			done <= 1'b0;
		end else begin
			// ready is high for exactly the cycle after the first access edge
			ready <= access;
			if (access) begin
				// block a second store while penable is still held
				done <= 1'b1;
			end else if (!(psel && penable)) begin
				// access phase over, arm for the next transfer
				done <= 1'b0;
			end
		end
	end

	// register writes and read data capture
	always_ff @(posedge pclk or negedge preset_n) begin
		if (!preset_n) begin
			for (int i = 0; i < apb_regs_pkg::REGS_PER_BANK; i++) begin
				mem[i] <= '0;
			end
			rd_data <= '0;
		end else if (access) begin
			if (pwrite) begin
				// store into the selected register only
				for (int i = 0; i < apb_regs_pkg::REGS_PER_BANK; i++) begin
					if (reg_sel[i]) begin
						mem[i] <= pwdata;
					end
				end
			end else begin
				// read data appears together with pready
				rd_data <= sel_data;
			end
		end
	end

	// response to the decoder
	assign rsp.prdata = rd_data;
	assign rsp.pready = ready;
	// a bank never flags an error
	assign rsp.pslverr = 1'b0;

endmodule

// File: hdl/apb_regs_pkg.sv
package apb_regs_pkg;

	// bus widths
	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;

	// register map geometry
	localparam int REGS_PER_BANK = 8;
	localparam int NUM_BANKS = 2;

	// bits below BANK_LSB pick the register inside a bank
	localparam int BANK_LSB = 3;

	// width of the register index field
	localparam int REG_IDX_W = BANK_LSB;

	// width of the bank index field, the upper address bits
	localparam int BANK_W = ADDR_W - BANK_LSB;

	// request from the bus master
	// psel and penable carry the setup and access phases
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	// response from a completer
	// pready is a single cycle pulse per transfer
	// pslverr is only valid together with pready
	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// one-hot register select inside a bank
	typedef logic [REGS_PER_BANK-1:0] reg_sel_t;

endpackage

// File: hdl/apb_regs_top.sv
`timescale 1ns/10ps

module apb_regs_top (
	input  logic pclk,
	input  logic preset_n,
	input  apb_regs_pkg::apb_req_t req,
	output apb_regs_pkg::apb_rsp_t rsp
);

	// per bank select from the decoder
	logic [apb_regs_pkg::NUM_BANKS-1:0] bank_psel;

	// one-hot register select, common to all banks
	apb_regs_pkg::reg_sel_t reg_sel;

	// responses coming back from the banks
	apb_regs_pkg::apb_rsp_t [apb_regs_pkg::NUM_BANKS-1:0] bank_rsp;

	// address decode, response merge and unmapped error handling
	apb_addr_decoder u_decoder (
		.pclk      (pclk),
		.preset_n  (preset_n),
		.req       (req),
		.bank_rsp  (bank_rsp),
		.bank_psel (bank_psel),
		.reg_sel   (reg_sel),
		.rsp       (rsp)
	);

	// register banks
	// penable, pwrite and pwdata go to every bank unchanged
	for (genvar b = 0; b < apb_regs_pkg::NUM_BANKS; b++) begin : g_bank
		apb_reg_bank u_bank (
			.pclk     (pclk),
			.preset_n (preset_n),
			.psel     (bank_psel[b]),
			.penable  (req.penable),
			.pwrite   (req.pwrite),
			.reg_sel  (reg_sel),
			.pwdata   (req.pwdata),
			.rsp      (bank_rsp[b])
		);
	end

endmodule

// File: tb/apb_regs_asserts.sv
`timescale 1ns/10ps

module apb_regs_asserts (
	input  logic pclk,
	input  logic preset_n,
	input  apb_regs_pkg::apb_req_t req,
	input  apb_regs_pkg::apb_rsp_t rsp
);

	// pready is a single cycle pulse
	ready_one_cycle: assert property (@(posedge pclk) disable iff (!preset_n)
		rsp.pready |=> !rsp.pready)
		else $error("pready held for more than one cycle");

	// an error response only comes with pready
	slverr_with_ready: assert property (@(posedge pclk) disable iff (!preset_n)
		rsp.pslverr |-> rsp.pready)
		else $error("pslverr high without pready");

	// master keeps the access phase and its fields until pready
	req_stable: assert property (@(posedge pclk) disable iff (!preset_n)
		req.psel && req.penable && !rsp.pready |=>
			req.psel && req.penable && $stable(req.paddr) &&
			$stable(req.pwrite) && $stable(req.pwdata))
		else $error("request changed during the access phase");

	// one fixed wait cycle after the first access cycle
	ready_latency: assert property (@(posedge pclk) disable iff (!preset_n)
		req.psel && req.penable && !$past(req.penable) |=> rsp.pready)
		else $error("pready not one cycle after the first access cycle");

endmodule

// attach to every instance of the top level
bind apb_regs_top apb_regs_asserts u_asserts (
	.pclk     (pclk),
	.preset_n (preset_n),
	.req      (req),
	.rsp      (rsp)
);

// File: tb/apb_regs_tb.sv
`timescale 1ns/10ps

module apb_regs_tb;

	typedef logic [apb_regs_pkg::ADDR_W-1:0] addr_t;
	typedef logic [apb_regs_pkg::DATA_W-1:0] data_t;

	// all mapped registers, bank after bank
	localparam int N_MAPPED = apb_regs_pkg::NUM_BANKS * apb_regs_pkg::REGS_PER_BANK;
	localparam int IDX_W = $clog2(N_MAPPED);
	localparam int N_UNMAPPED = 8;
	localparam int N_RANDOM = 200;
	// reset read, write pass, readback, readback after unmapped, read after reset
	localparam int N_XFERS = 5 * N_MAPPED + N_UNMAPPED + N_RANDOM;
	localparam int TIMEOUT_CYCLES = 3 * N_XFERS + 50;
	// rising edges from the setup cycle up to the one that sees pready
	localparam int READY_LATENCY = 3;
	localparam int WAIT_LIMIT = 8;
	localparam logic [31:0] SEED = 32'he0ea0e3f;

	logic pclk;
	logic preset_n;
	logic reset_req;
	apb_regs_pkg::apb_req_t req;
	apb_regs_pkg::apb_rsp_t rsp;

	// expected register contents
	data_t model [N_MAPPED];

	int check_errors = 0;
	int seq_errors = 0;
	int checked = 0;
	int cycles = 0;

	tb_clock_gen u_clock (
		.reset_req (reset_req),
		.pclk      (pclk),
		.preset_n  (preset_n)
	);

	apb_regs_top dut (
		.pclk     (pclk),
		.preset_n (preset_n),
		.req      (req),
		.rsp      (rsp)
	);

	// bank index in the upper bits, register in the lower bits
	function automatic logic is_mapped(input addr_t addr);
		int bank;
		bank = int'(addr[apb_regs_pkg::ADDR_W-1:apb_regs_pkg::BANK_LSB]);
		return bank < apb_regs_pkg::NUM_BANKS;
	endfunction

	// position of a mapped register in the model
	function automatic logic [IDX_W-1:0] model_index(input addr_t addr);
		int bank;
		int reg_no;
		bank = int'(addr[apb_regs_pkg::ADDR_W-1:apb_regs_pkg::BANK_LSB]);
		reg_no = int'(addr[apb_regs_pkg::BANK_LSB-1:0]);
		return IDX_W'(bank * apb_regs_pkg::REGS_PER_BANK + reg_no);
	endfunction

	// reference response for an access to addr
	// unmapped gives an error with zero data, mapped gives the stored byte
	function automatic apb_regs_pkg::apb_rsp_t expected_rsp(
		input addr_t addr,
		input data_t mem [N_MAPPED]
	);
		apb_regs_pkg::apb_rsp_t r;
		r.pready = 1'b1;
		r.pslverr = 1'b0;
		r.prdata = '0;
		if (!is_mapped(addr)) begin
			r.pslverr = 1'b1;
		end else begin
			r.prdata = mem[model_index(addr)];
		end
		return r;
	endfunction

	// compare on the edge that ends each transfer
	// values read here are the ones held during the ready cycle
	always @(posedge pclk) begin : compare
		apb_regs_pkg::apb_rsp_t want;
		if (!preset_n) begin
			// reset clears every register
			for (int i = 0; i < N_MAPPED; i++) begin
				model[i] = '0;
			end
		end else if (rsp.pready) begin
			if (!(req.psel && req.penable)) begin
				check_errors++;
				$display("error at %0d ns: pready high outside an access phase", $time);
			end else begin
				want = expected_rsp(req.paddr, model);
				checked++;
				if (rsp.pslverr !== want.pslverr) begin
					check_errors++;
					$display("FAIL %0d ns: addr %02h pslverr %0b, expected %0b",
						$time, req.paddr, rsp.pslverr, want.pslverr);
				end
				// a write to a mapped register returns no defined data
				if ((!req.pwrite || want.pslverr) && rsp.prdata !== want.prdata) begin
					check_errors++;
					$display("FAIL %0d ns: addr %02h prdata %02h, expected %02h",
						$time, req.paddr, rsp.prdata, want.prdata);
				end
				// only mapped writes change the model
				if (req.pwrite && !want.pslverr) begin
					model[model_index(req.paddr)] = req.pwdata;
				end
			end
		end
	end

	// run limit
	always @(posedge pclk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: test not finished after %0d cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// setup, access, then wait for pready
	// called on a falling edge, returns on a falling edge with the bus idle
	task automatic run_transfer(input apb_regs_pkg::apb_req_t setup);
		int waited;
		logic seen;
		req = setup;
		req.penable = 1'b0;
		@(posedge pclk);
		waited = 1;
		seen = 1'b0;
		@(negedge pclk);
		req.penable = 1'b1;
		while (!seen && waited < WAIT_LIMIT) begin
			@(posedge pclk);
			waited++;
			seen = rsp.pready;
		end
		if (!seen) begin
			seq_errors++;
			$display("error at %0d ns: no pready for address %02h", $time, setup.paddr);
		end else if (waited != READY_LATENCY) begin
			seq_errors++;
			$display("FAIL %0d ns: addr %02h pready after %0d cycles, expected %0d",
				$time, setup.paddr, waited, READY_LATENCY);
		end
		@(negedge pclk);
		req = '0;
	endtask

	task automatic write_reg(input addr_t addr, input data_t data);
		apb_regs_pkg::apb_req_t r;
		r = '0;
		r.psel = 1'b1;
		r.pwrite = 1'b1;
		r.paddr = addr;
		r.pwdata = data;
		run_transfer(r);
	endtask

	task automatic read_reg(input addr_t addr);
		apb_regs_pkg::apb_req_t r;
		r = '0;
		r.psel = 1'b1;
		r.paddr = addr;
		run_transfer(r);
	endtask

	// every mapped register once, checked by the compare process
	task automatic read_all_mapped();
		for (int a = 0; a < N_MAPPED; a++) begin
			read_reg(addr_t'(a));
		end
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		addr_t unmapped_addr [4];
		req = '0;
		reset_req = 1'b0;
		void'($urandom(SEED));
		@(posedge preset_n);
		@(negedge pclk);

		// registers come out of reset as zero
		read_all_mapped();

		// distinct byte per register, 17 is odd so no two collide
		for (int a = 0; a < N_MAPPED; a++) begin
			write_reg(addr_t'(a), data_t'(a * 17 + 33));
		end
		read_all_mapped();

		// unmapped banks, first and last index plus two random ones
		unmapped_addr[0] = addr_t'(N_MAPPED);
		unmapped_addr[1] = '1;
		for (int i = 2; i < 4; i++) begin
			rnd = $urandom();
			unmapped_addr[i] = addr_t'(N_MAPPED + int'(rnd % (256 - N_MAPPED)));
		end
		for (int i = 0; i < 4; i++) begin
			rnd = $urandom();
			write_reg(unmapped_addr[i], rnd[7:0]);
		end
		for (int i = 0; i < 4; i++) begin
			read_reg(unmapped_addr[i]);
		end
		// mapped contents unchanged
		read_all_mapped();

		// random mix, half of the addresses forced into the mapped range
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $urandom();
			if (rnd[17]) begin
				rnd[7:4] = 4'h0;
			end
			if (rnd[16]) begin
				write_reg(rnd[7:0], rnd[15:8]);
			end else begin
				read_reg(rnd[7:0]);
			end
		end

		// reset in the middle of the run
		reset_req = 1'b1;
		repeat (3) @(negedge pclk);
		reset_req = 1'b0;
		@(negedge pclk);
		read_all_mapped();

		repeat (2) @(negedge pclk);
		$display("checked %0d transfers, %0d compare errors, %0d handshake errors",
			checked, check_errors, seq_errors);
		if (check_errors == 0 && seq_errors == 0 && checked == N_XFERS) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	input  logic reset_req,
	output logic pclk,
	output logic preset_n
);

	// power-on part of the reset
	logic por_n;

	// 20 ns period, toggles every half period
	initial begin
		pclk = 1'b0;
		forever begin
			#10 pclk = ~pclk;
		end
	end

	// low for three full cycles, released on a falling edge
	initial begin
		por_n = 1'b0;
		repeat (3) @(posedge pclk);
		@(negedge pclk);
		por_n = 1'b1;
	end

	// the testbench can pull reset again in the middle of the run
	assign preset_n = por_n && !reset_req;

endmodule
